/* Bender.yml */
package:
  name: lut_unit

sources:
  - include_dirs:
      - .
    files:
      - lut_pkg.sv
      - lut_addr_gen.sv
      - lut_mem_writer.sv
      - lut_dp_ram.sv
      - lut_read.sv
      - lut_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lut_unit.sv

/* flist.f */
+incdir+.
lut_pkg.sv
lut_addr_gen.sv
lut_mem_writer.sv
lut_dp_ram.sv
lut_read.sv
lut_unit_top.sv
tb_lut_unit.sv

/* lut_addr_gen.sv */
`include "lut_cfg.svh"

module lut_addr_gen (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  lut_pkg::ram_addr_t iterations,
   input  lut_pkg::ram_addr_t period,
   input  lut_pkg::ram_addr_t duty,
   input  lut_pkg::ram_addr_t shift,
   input  lut_pkg::ram_addr_t incr,
   input  logic               next,
   output logic               ready,
   output lut_pkg::ram_addr_t addr,
   output logic               done
);

   lut_pkg::gen_state_t state;
   lut_pkg::ram_addr_t  iter_cnt;
   lut_pkg::ram_addr_t  per_cnt;
   logic                active;
   logic                step;
   logic                per_end;
   logic                last_iter;

   assign active = (state == lut_pkg::GEN_ACTIVE);

   // Only the first duty steps of a period are offered to the consumer
   assign ready = active && (per_cnt < duty);

   // Inside the duty window a step waits for next,
   // outside it the counters move on by themselves
   assign step = active && (ready ? next : 1'b1);

   assign per_end   = (per_cnt == period - 1'b1);
   assign last_iter = (iter_cnt == iterations - 1'b1);

   assign done = (state == lut_pkg::GEN_FINISH);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= lut_pkg::GEN_IDLE;
         iter_cnt <= '0;
         per_cnt  <= '0;
         addr     <= '0;
      end else if (start) begin
         iter_cnt <= '0;
         per_cnt  <= '0;
         addr     <= '0;
         // Empty loop nest has nothing to generate
         if (iterations == '0 || period == '0) begin
            state <= lut_pkg::GEN_FINISH;
         end else begin
            state <= lut_pkg::GEN_ACTIVE;
         end
      end else if (step) begin
         if (per_end) begin
            // Period wrap, the shift comes on top of the normal increment
            per_cnt  <= '0;
            addr     <= addr + incr + shift;
            iter_cnt <= iter_cnt + 1'b1;
            if (last_iter) begin
               state <= lut_pkg::GEN_FINISH;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr    <= addr + incr;
         end
      end
   end

endmodule

/* lut_cfg.svh */
`ifndef LUT_CFG_SVH
`define LUT_CFG_SVH

// Width of one table entry
`define LUT_DATA_W 32

// Bus and RAM word width
// Must hold a power-of-two number of entries, at least two
`define LUT_BUS_W 64

// RAM word address width
// In ping-pong mode the top bit picks the bank
`define LUT_RAM_AW 9

// External byte address width
`define LUT_EXT_AW 32

// Burst length field, beats minus one
`define LUT_LEN_W 8

`endif

/* lut_dp_ram.sv */
`include "lut_cfg.svh"

module lut_dp_ram (
   input  logic               clk,
   input  logic               wr_en,
   input  lut_pkg::ram_addr_t wr_addr,
   input  lut_pkg::word_t     wr_data,
   input  lut_pkg::ram_addr_t rd_addr,
   output lut_pkg::word_t     rd_data
);

   localparam int DEPTH = 1 << `LUT_RAM_AW;

   lut_pkg::word_t mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read port, data one cycle after the address
   // A read of the word being written returns the old contents
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* lut_mem_writer.sv */
`include "lut_cfg.svh"

module lut_mem_writer (
   input  logic               clk,
   input  logic               rst,
   input  logic               gen_valid,
   input  logic               gen_ready,
   input  lut_pkg::ram_addr_t gen_addr,
   output logic               next,
   input  logic               beat_valid,
   output logic               beat_ready,
   input  lut_pkg::word_t     beat_data,
   output logic               wr_en,
   output lut_pkg::ram_addr_t wr_addr,
   output lut_pkg::word_t     wr_data
);

   // Ask the bus for a word only while a target address is on offer
   assign beat_ready = gen_valid && gen_ready;

   // A transferred beat uses up the current address
   assign next = beat_ready && beat_valid;

   // Write stage, one RAM write per transferred beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= next;
      end
   end

   always_ff @(posedge clk) begin
      if (next) begin
         wr_addr <= gen_addr;
         wr_data <= beat_data;
      end
   end

endmodule

/* lut_pkg.sv */
`include "lut_cfg.svh"

package lut_pkg;

   // One table entry as seen on in0/out0
   typedef logic [`LUT_DATA_W-1:0] data_t;

   // One bus beat, which is also one RAM word
   typedef logic [`LUT_BUS_W-1:0] word_t;

   // RAM word address, also used for the generator settings
   typedef logic [`LUT_RAM_AW-1:0] ram_addr_t;

   // External byte address
   typedef logic [`LUT_EXT_AW-1:0] ext_addr_t;

   // Burst length minus one
   typedef logic [`LUT_LEN_W-1:0] len_t;

   // Address generator FSM
   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_ACTIVE,
      GEN_FINISH
   } gen_state_t;

endpackage

/* lut_read.sv */
`include "lut_cfg.svh"

module lut_read (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  logic               running,
   input  logic               disabled,
   input  logic               pingpong,
   input  lut_pkg::ext_addr_t ext_addr,
   input  lut_pkg::len_t      length,
   input  lut_pkg::ram_addr_t iter,
   input  lut_pkg::ram_addr_t per,
   input  lut_pkg::ram_addr_t duty,
   input  lut_pkg::ram_addr_t shift,
   input  lut_pkg::ram_addr_t incr,
   input  lut_pkg::data_t     in0,
   output lut_pkg::data_t     out0,
   output logic               done,
   output logic               databus_valid,
   input  logic               databus_ready,
   output lut_pkg::ext_addr_t databus_addr,
   output lut_pkg::len_t      databus_len,
   input  lut_pkg::word_t     databus_rdata,
   input  logic               databus_last,
   output lut_pkg::ram_addr_t rd_addr,
   input  lut_pkg::word_t     rd_data,
   output logic               wr_en,
   output lut_pkg::ram_addr_t wr_addr,
   output lut_pkg::word_t     wr_data
);

   localparam int LANES  = `LUT_BUS_W / `LUT_DATA_W;
   localparam int LANE_W = $clog2(LANES);
   localparam int TOP    = `LUT_RAM_AW - 1;

   logic               load_start;
   logic               last_beat;
   logic               bank;
   logic               gen_valid;
   logic               gen_ready;
   logic               gen_next;
   logic               gen_done;
   lut_pkg::ram_addr_t gen_addr;
   lut_pkg::ram_addr_t wr_addr_raw;
   lut_pkg::ram_addr_t rd_addr_d;
   logic [LANE_W-1:0]  sel_0;
   logic [LANE_W-1:0]  sel_1;

   assign load_start = run && !disabled;
   assign last_beat  = databus_valid && databus_ready && databus_last;
   assign databus_len = length;

   // Load status
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done <= 1'b1;
      end else if (load_start) begin
         done <= 1'b0;
      end else if (last_beat) begin
         done <= 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         databus_addr <= '0;
      end else if (load_start) begin
         databus_addr <= ext_addr;
      end
   end

   // Bus request window, also closed if the generator runs dry
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         gen_valid <= 1'b0;
      end else if (run) begin
         gen_valid <= !disabled;
      end else if (running && last_beat) begin
         gen_valid <= 1'b0;
      end else if (gen_done) begin
         gen_valid <= 1'b0;
      end
   end

   // Bank written by the current load; reads use the other one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (run) begin
         bank <= pingpong ? !bank : 1'b0;
      end
   end

   lut_addr_gen i_addr_gen (
      .clk        (clk),
      .rst        (rst),
      .start      (load_start),
      .iterations (iter),
      .period     (per),
      .duty       (duty),
      .shift      (shift),
      .incr       (incr),
      .next       (gen_next),
      .ready      (gen_ready),
      .addr       (gen_addr),
      .done       (gen_done)
   );

   lut_mem_writer i_writer (
      .clk        (clk),
      .rst        (rst),
      .gen_valid  (gen_valid),
      .gen_ready  (gen_ready),
      .gen_addr   (gen_addr),
      .next       (gen_next),
      .beat_valid (databus_ready),
      .beat_ready (databus_valid),
      .beat_data  (databus_rdata),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr_raw),
      .wr_data    (wr_data)
   );

   always_comb begin
      wr_addr = wr_addr_raw;
      if (pingpong) begin
         wr_addr[TOP] = bank ^ wr_addr_raw[TOP];
      end
   end

   // Word address is the index above the lane bits
   always_comb begin
      rd_addr_d = in0[LANE_W +: `LUT_RAM_AW];
      if (pingpong) begin
         rd_addr_d[TOP] = !bank;
      end
   end

   // Lookup pipe: address and lane, then lane follows the RAM read
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
         sel_0   <= '0;
         sel_1   <= '0;
      end else begin
         rd_addr <= rd_addr_d;
         sel_0   <= in0[LANE_W-1:0];
         sel_1   <= sel_0;
      end
   end

   assign out0 = rd_data[sel_1 * `LUT_DATA_W +: `LUT_DATA_W];

endmodule

/* lut_unit_top.sv */
`include "lut_cfg.svh"

module lut_unit_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  logic               running,
   input  logic               disabled,
   input  logic               pingpong,
   input  lut_pkg::ext_addr_t ext_addr,
   input  lut_pkg::len_t      length,
   input  lut_pkg::ram_addr_t iter,
   input  lut_pkg::ram_addr_t per,
   input  lut_pkg::ram_addr_t duty,
   input  lut_pkg::ram_addr_t shift,
   input  lut_pkg::ram_addr_t incr,
   input  lut_pkg::data_t     in0,
   output lut_pkg::data_t     out0,
   output logic               done,
   output logic               databus_valid,
   input  logic               databus_ready,
   output lut_pkg::ext_addr_t databus_addr,
   output lut_pkg::len_t      databus_len,
   input  lut_pkg::word_t     databus_rdata,
   input  logic               databus_last
);

   // Table RAM ports
   lut_pkg::ram_addr_t rd_addr;
   lut_pkg::word_t     rd_data;
   logic               wr_en;
   lut_pkg::ram_addr_t wr_addr;
   lut_pkg::word_t     wr_data;

   lut_read i_read (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .running       (running),
      .disabled      (disabled),
      .pingpong      (pingpong),
      .ext_addr      (ext_addr),
      .length        (length),
      .iter          (iter),
      .per           (per),
      .duty          (duty),
      .shift         (shift),
      .incr          (incr),
      .in0           (in0),
      .out0          (out0),
      .done          (done),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_addr  (databus_addr),
      .databus_len   (databus_len),
      .databus_rdata (databus_rdata),
      .databus_last  (databus_last),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data)
   );

   lut_dp_ram i_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* tb_lut_unit.sv */
`include "lut_cfg.svh"

module tb_lut_unit;

   localparam int LANES     = `LUT_BUS_W / `LUT_DATA_W;
   localparam int TOP       = `LUT_RAM_AW - 1;
   localparam int BYTE_SH   = $clog2(`LUT_BUS_W / 8);
   localparam int EXT_WORDS = 1024;

   typedef struct packed {
      logic               dis;
      logic               pp;
      logic               early;
      lut_pkg::ext_addr_t ext;
      lut_pkg::len_t      len;
      lut_pkg::ram_addr_t iter, per, duty, shift, incr;
      int                 rd_first;
      int                 rd_count;
   } op_t;

   logic clk, rst, run, running, disabled, pingpong;
   lut_pkg::ext_addr_t ext_addr;
   lut_pkg::len_t      length;
   lut_pkg::ram_addr_t iter, per, duty, shift, incr;
   lut_pkg::data_t     in0, out0;
   logic               done, databus_valid, databus_ready, databus_last;
   lut_pkg::ext_addr_t databus_addr;
   lut_pkg::len_t      databus_len;
   lut_pkg::word_t     databus_rdata;

   // Memory behind the bus and the expected RAM contents
   lut_pkg::word_t ext_mem [EXT_WORDS];
   lut_pkg::word_t ref_ram [1 << `LUT_RAM_AW];
   logic bank_m = 1'b0;
   logic pp_m = 1'b0;

   op_t ops[$];
   int  err_data = 0;
   int  err_done = 0;
   int  err_addr = 0;
   int  err_len = 0;
   int  cycles = 0;
   int  limit = 0;
   int  beat = 0;
   int  base = 0;
   logic [15:0] lfsr;

   // Expected-value pipe, two edges behind in0
   logic rd_v, v1, v2;
   lut_pkg::data_t rd_exp, e1, e2;

   lut_unit_top i_lut_unit_top (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic check_data(input lut_pkg::data_t got, input lut_pkg::data_t exp);
      if (got !== exp) begin
         err_data++;
         $display("CHECK FAILED at %0t: out0 got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_done(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_done++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input lut_pkg::ext_addr_t got, input lut_pkg::ext_addr_t exp);
      if (got !== exp) begin
         err_addr++;
         $display("CHECK FAILED at %0t: databus_addr got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_len(input lut_pkg::len_t got, input lut_pkg::len_t exp);
      if (got !== exp) begin
         err_len++;
         $display("CHECK FAILED at %0t: databus_len got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic add_op(input logic dis, input logic pp, input logic early,
                         input int ext, input int len, input int it, input int pe,
                         input int du, input int sh, input int inc, input int first,
                         input int cnt);
      op_t op;
      op.dis = dis;
      op.pp = pp;
      op.early = early;
      op.ext = lut_pkg::ext_addr_t'(ext);
      op.len = lut_pkg::len_t'(len);
      op.iter = lut_pkg::ram_addr_t'(it);
      op.per = lut_pkg::ram_addr_t'(pe);
      op.duty = lut_pkg::ram_addr_t'(du);
      op.shift = lut_pkg::ram_addr_t'(sh);
      op.incr = lut_pkg::ram_addr_t'(inc);
      op.rd_first = first;
      op.rd_count = cnt;
      ops.push_back(op);
   endtask

   // Nested-loop address walk, each presented address takes the next bus word
   task automatic update_model(input op_t op);
      int a;
      int j;
      int it;
      int p;
      lut_pkg::ram_addr_t wa;
      a = 0;
      j = 0;
      for (it = 0; it < op.iter; it++) begin
         for (p = 0; p < op.per; p++) begin
            if (p < op.duty && j <= op.len) begin
               wa = lut_pkg::ram_addr_t'(a);
               if (op.pp) wa[TOP] = wa[TOP] ^ bank_m;
               ref_ram[wa] = ext_mem[(int'(op.ext >> BYTE_SH) + j) % EXT_WORDS];
               j++;
            end
            a += op.incr;
         end
         a += op.shift;
      end
   endtask

   function automatic lut_pkg::data_t exp_entry(input int idx);
      lut_pkg::ram_addr_t wa;
      lut_pkg::word_t w;
      wa = lut_pkg::ram_addr_t'(idx / LANES);
      if (pp_m) wa[TOP] = !bank_m;
      w = ref_ram[wa];
      return w[(idx % LANES) * `LUT_DATA_W +: `LUT_DATA_W];
   endfunction

   task automatic read_stream(input int first, input int count);
      int i;
      for (i = 0; i < count; i++) begin
         @(posedge clk);
         in0 <= lut_pkg::data_t'(first + i);
         rd_v <= 1'b1;
         rd_exp <= exp_entry(first + i);
      end
      @(posedge clk);
      rd_v <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   task automatic apply_op(input op_t op);
      @(posedge clk);
      run <= 1'b1;
      disabled <= op.dis;
      pingpong <= op.pp;
      ext_addr <= op.ext;
      length <= op.len;
      iter <= op.iter;
      per <= op.per;
      duty <= op.duty;
      shift <= op.shift;
      incr <= op.incr;
      @(posedge clk);
      run <= 1'b0;
      pp_m = op.pp;
      bank_m = op.pp ? !bank_m : 1'b0;
      if (!op.dis) update_model(op);
      @(negedge clk);
      check_done(done, op.dis, "done after run");
      check_len(databus_len, op.len);
      if (op.dis) begin
         repeat (4) begin
            @(negedge clk);
            check_done(done, 1'b1, "done on disabled run");
            check_done(databus_valid, 1'b0, "databus_valid on disabled run");
         end
      end else begin
         check_addr(databus_addr, op.ext);
         check_done(databus_valid, 1'b1, "databus_valid after run");
         if (op.early) read_stream(op.rd_first, op.rd_count);
         while (!done) @(negedge clk);
         // Last beat lands in RAM one edge after done rises
         repeat (2) @(posedge clk);
      end
      if (op.dis || !op.early) read_stream(op.rd_first, op.rd_count);
   endtask

   // Bus memory, ready gated by the LFSR
   always @(posedge clk) begin : bus_model
      int b;
      int bw;
      logic [15:0] s;
      if (rst) begin
         lfsr <= 16'd10629;
         beat <= 0;
         databus_ready <= 1'b0;
         databus_last <= 1'b0;
      end else begin
         b = beat;
         bw = base;
         if (databus_valid && databus_ready) b = b + 1;
         if (run) begin
            b = 0;
            bw = int'(ext_addr >> BYTE_SH);
         end
         s = lfsr_step(lfsr);
         lfsr <= s;
         beat <= b;
         base <= bw;
         databus_ready <= s[0];
         databus_rdata <= ext_mem[(bw + b) % EXT_WORDS];
         databus_last <= (b == int'(databus_len));
      end
   end

   always @(posedge clk) begin
      v1 <= rd_v;
      e1 <= rd_exp;
      v2 <= v1;
      e2 <= e1;
   end

   always @(negedge clk) begin
      if (v2 === 1'b1) check_data(out0, e2);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout after %0d cycles, a load or read stream stalled", cycles);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      int k;
      rst = 1'b1;
      run = 1'b0;
      running = 1'b1;
      disabled = 1'b0;
      pingpong = 1'b0;
      ext_addr = '0;
      length = '0;
      {iter, per, duty, shift, incr} = '0;
      in0 = '0;
      databus_ready = 1'b0;
      databus_rdata = '0;
      databus_last = 1'b0;
      rd_v = 1'b0;
      rd_exp = '0;
      v1 = 1'b0;
      v2 = 1'b0;
      for (k = 0; k < EXT_WORDS; k++) begin
         ext_mem[k] = {32'hB000_0000 + k, 32'hA000_0000 + k};
      end
      // dis pp early ext len iter per duty shift incr first reads
      add_op(0, 0, 0, 'h100, 15, 1, 16, 16, 0, 1, 0, 32);
      add_op(1, 0, 0, 'h200, 15, 1, 16, 16, 0, 1, 8, 24);
      add_op(0, 0, 0, 'h400, 3, 2, 4, 2, 1, 2, 0, 32);
      add_op(0, 1, 1, 'h600, 15, 1, 16, 16, 0, 1, 0, 32);
      add_op(0, 1, 1, 'h700, 15, 1, 16, 16, 0, 1, 0, 32);
      add_op(1, 1, 0, 'h800, 15, 1, 16, 16, 0, 1, 4, 28);
      foreach (ops[i]) begin
         limit += 4 * ((ops[i].dis ? 0 : int'(ops[i].len) + 1) + ops[i].rd_count) + 40;
      end
      limit += 100;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_done(done, 1'b1, "done after reset");
      check_done(databus_valid, 1'b0, "databus_valid after reset");
      foreach (ops[i]) apply_op(ops[i]);
      repeat (4) @(posedge clk);
      $display("Errors: data %0d, done %0d, addr %0d, len %0d",
               err_data, err_done, err_addr, err_len);
      if (err_data + err_done + err_addr + err_len == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
